// ==== approx_mult_8x8.sv ====
`timescale 1ns/10ps

module approx_mult_8x8 (
    input  lenet_pkg::pix_t  x,
    input  lenet_pkg::wgt_t  y,
    output lenet_pkg::prod_t z
);

    lenet_pkg::wgt_t  row [lenet_pkg::PIX_W];

    // correction bits, grouped by the weight they carry.
    logic             t2;
    logic             t3;
    logic [2:0]       t6;
    logic [4:0]       t7;
    logic [5:0]       t8;
    logic [1:0]       t9;
    logic [3:0]       t10;
    logic             t11;
    logic [1:0]       t12;

    lenet_pkg::prod_t exact_sum;
    lenet_pkg::prod_t corr_sum;

    // number of set bits, widened to the product width.
    function automatic lenet_pkg::prod_t ones(input logic [5:0] bits);
        lenet_pkg::prod_t n;
        n = '0;
        for (int i = 0; i < 6; i++) begin
            n = n + lenet_pkg::prod_t'(bits[i]);
        end
        return n;
    endfunction

    always_comb begin
        for (int r = 0; r < lenet_pkg::PIX_W; r++) begin
            row[r] = y & {lenet_pkg::WGT_W{x[r]}};
        end
    end

    // weight 2^2 and 2^3.
    assign t2     = row[0][1] | row[1][0];
    assign t3     = row[0][2] ^ row[1][1];

    // weight 2^6.
    assign t6[0]  = row[0][6] ^ row[1][5];
    assign t6[1]  = row[2][4] & row[3][3];
    assign t6[2]  = row[4][1] | row[5][0];

    // weight 2^7.
    assign t7[0]  = row[0][7] | row[1][6];
    assign t7[1]  = row[2][4] | row[3][3];
    assign t7[2]  = row[2][5] | row[3][4];
    assign t7[3]  = row[4][2] | row[5][1];
    assign t7[4]  = row[4][3] | row[5][2];

    // weight 2^8.
    assign t8[0]  = row[0][7] & row[1][6];
    assign t8[1]  = row[1][7];
    assign t8[2]  = row[2][5] & row[3][4];
    assign t8[3]  = row[2][6] | row[3][5];
    assign t8[4]  = row[4][4] & row[5][3];
    assign t8[5]  = row[4][4] ^ row[5][3];

    // weight 2^9.
    assign t9[0]  = row[2][7] | row[3][6];
    assign t9[1]  = row[4][5] ^ row[5][4];

    // weight 2^10.
    assign t10[0] = row[3][7];
    assign t10[1] = row[4][5] & row[5][4];
    assign t10[2] = row[4][6] & row[5][5];
    assign t10[3] = row[4][6] | row[5][5];

    // weight 2^11 and 2^12.
    assign t11    = row[4][7] ^ row[5][6];
    assign t12[0] = row[4][7] & row[5][6];
    assign t12[1] = row[5][7];

    // rows 6 and 7 stay exact.
    assign exact_sum = (lenet_pkg::prod_t'(row[6]) << 6)
                     + (lenet_pkg::prod_t'(row[7]) << 7);

    assign corr_sum = (ones(6'(t2))  << 2)
                    + (ones(6'(t3))  << 3)
                    + (ones(6'(t6))  << 6)
                    + (ones(6'(t7))  << 7)
                    + (ones(t8)      << 8)
                    + (ones(6'(t9))  << 9)
                    + (ones(6'(t10)) << 10)
                    + (ones(6'(t11)) << 11)
                    + (ones(6'(t12)) << 12);

    assign z = exact_sum + corr_sum;   // wraps at 16 bits.

endmodule

// ==== conv_ctrl.sv ====
`timescale 1ns/10ps

module conv_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic in_valid,
    input  logic last,
    output logic cnt_clear,
    output logic cnt_inc,
    mac_if.ctrl  bus,
    output logic busy,
    output logic done
);

    lenet_pkg::ctrl_state_t state;
    lenet_pkg::ctrl_state_t state_nxt;
    logic                   open_win;
    logic                   take_tap;

    assign open_win = (state == lenet_pkg::IDLE) && start;
    assign take_tap = (state == lenet_pkg::ACCUM) && in_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            lenet_pkg::IDLE: begin
                if (start) begin
                    state_nxt = lenet_pkg::ACCUM;
                end
            end
            lenet_pkg::ACCUM: begin
                if (in_valid && last) begin
                    state_nxt = lenet_pkg::FLUSH;   // final tap taken.
                end
            end
            lenet_pkg::FLUSH: begin
                state_nxt = lenet_pkg::FINISH;   // last product lands in the sum.
            end
            lenet_pkg::FINISH: begin
                state_nxt = lenet_pkg::IDLE;
            end
            default: begin
                state_nxt = lenet_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= lenet_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // a new window wipes the counter and the sum.
    assign cnt_clear     = open_win;
    assign bus.clear_acc = open_win;

    assign cnt_inc    = take_tap;
    assign bus.tap_en = take_tap;

    assign busy = (state != lenet_pkg::IDLE);
    assign done = (state == lenet_pkg::FINISH);

endmodule

// ==== conv_tap_engine.sv ====
`timescale 1ns/10ps

module conv_tap_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             in_valid,
    input  lenet_pkg::pix_t  pix,
    input  lenet_pkg::wgt_t  wgt,
    output logic             busy,
    output logic             done,
    output lenet_pkg::acc_t  acc_out
);

    logic cnt_clear;
    logic cnt_inc;
    logic last;

    mac_if mac_bus ();

    // operands go straight to the multiplier.
    assign mac_bus.pix = pix;
    assign mac_bus.wgt = wgt;

    conv_ctrl conv_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .in_valid  (in_valid),
        .last      (last),
        .cnt_clear (cnt_clear),
        .cnt_inc   (cnt_inc),
        .bus       (mac_bus),
        .busy      (busy),
        .done      (done)
    );

    tap_counter tap_counter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cnt_clear),
        .inc   (cnt_inc),
        .last  (last)
    );

    mac_datapath mac_datapath_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mac_bus)
    );

    assign acc_out = mac_bus.acc;   // holds until the next start.

endmodule

// ==== lenet_pkg.sv ====
package lenet_pkg;

    // operand and result widths.
    localparam int PIX_W     = 8;
    localparam int WGT_W     = 8;
    localparam int PROD_W    = 16;
    localparam int ACC_W     = 21;   // 25 * 65535 fits in 21 bits.
    localparam int TAP_IDX_W = 5;

    // one 5x5 window.
    localparam int TAP_COUNT = 25;

    typedef logic [PIX_W-1:0]     pix_t;
    typedef logic [WGT_W-1:0]     wgt_t;
    typedef logic [PROD_W-1:0]    prod_t;
    typedef logic [ACC_W-1:0]     acc_t;
    typedef logic [TAP_IDX_W-1:0] tap_idx_t;

    // window controller states.
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        FLUSH,
        FINISH
    } ctrl_state_t;

endpackage

// ==== mac_datapath.sv ====
`timescale 1ns/10ps

module mac_datapath (
    input logic clk,
    input logic rst_n,
    mac_if.dp   bus
);

    lenet_pkg::prod_t prod_d;
    lenet_pkg::prod_t prod_q;
    logic             prod_vld;
    lenet_pkg::acc_t  acc_q;

    approx_mult_8x8 mult_inst (
        .x (bus.pix),
        .y (bus.wgt),
        .z (prod_d)
    );

    // product stage payload, qualified by prod_vld.
    always_ff @(posedge clk) begin
        if (bus.tap_en) begin
            prod_q <= prod_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_vld <= 1'b0;
            acc_q    <= '0;
        end else if (bus.clear_acc) begin
            prod_vld <= 1'b0;   // drop anything in flight.
            acc_q    <= '0;
        end else begin
            prod_vld <= bus.tap_en;
            if (prod_vld) begin
                acc_q <= acc_q + lenet_pkg::acc_t'(prod_q);
            end
        end
    end

    assign bus.acc = acc_q;

endmodule

// ==== mac_if.sv ====
`timescale 1ns/10ps

interface mac_if;

    logic               clear_acc;   // empties the product stage and the sum.
    logic               tap_en;      // one pair taken per high edge.
    lenet_pkg::pix_t    pix;
    lenet_pkg::wgt_t    wgt;
    lenet_pkg::acc_t    acc;

    modport ctrl (
        output clear_acc,
        output tap_en
    );

    modport dp (
        input  clear_acc,
        input  tap_en,
        input  pix,
        input  wgt,
        output acc
    );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_conv_tap_engine -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_conv_tap_engine)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// ==== src.f ====
lenet_pkg.sv
mac_if.sv
approx_mult_8x8.sv
mac_datapath.sv
tap_counter.sv
conv_ctrl.sv
conv_tap_engine.sv
tb_conv_tap_engine.sv

// ==== tap_counter.sv ====
`timescale 1ns/10ps

module tap_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic inc,
    output logic last
);

    lenet_pkg::tap_idx_t count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inc) begin
            count <= count + 1'b1;
        end
    end

    // high while the next accepted tap closes the window.
    assign last = (count == lenet_pkg::tap_idx_t'(lenet_pkg::TAP_COUNT - 1));

endmodule

// ==== tb_conv_tap_engine.sv ====
`timescale 1ns/10ps

module tb_conv_tap_engine;

    localparam int WAIT_LIMIT = 100;   // cycles allowed for done to show up.

    logic            clk;
    logic            rst_n;
    logic            start;
    logic            in_valid;
    lenet_pkg::pix_t pix;
    lenet_pkg::wgt_t wgt;
    logic            busy;
    logic            done;
    lenet_pkg::acc_t acc_out;

    logic [15:0]     lfsr;
    int              errors;
    int              checks;
    lenet_pkg::acc_t exp_acc;
    string           test_name;

    conv_tap_engine conv_tap_engine_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .in_valid (in_valid),
        .pix      (pix),
        .wgt      (wgt),
        .busy     (busy),
        .done     (done),
        .acc_out  (acc_out)
    );

    always #2 clk = ~clk;

    // galois form with taps x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};   // one step per bit.
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int weighted(input logic b, input int k);
        return b ? (1 << k) : 0;
    endfunction

    // approximate product rebuilt from the row and correction rules.
    function automatic logic [15:0] approx_ref(input logic [7:0] x, input logic [7:0] y);
        logic [7:0] p [8];
        int         s;
        for (int r = 0; r < 8; r++) begin
            p[r] = x[r] ? y : 8'h00;
        end
        s = (int'(p[6]) << 6) + (int'(p[7]) << 7);
        s += weighted(p[0][1] | p[1][0], 2);
        s += weighted(p[0][2] ^ p[1][1], 3);
        s += weighted(p[0][6] ^ p[1][5], 6);
        s += weighted(p[2][4] & p[3][3], 6);
        s += weighted(p[4][1] | p[5][0], 6);
        s += weighted(p[0][7] | p[1][6], 7);
        s += weighted(p[2][4] | p[3][3], 7);
        s += weighted(p[2][5] | p[3][4], 7);
        s += weighted(p[4][2] | p[5][1], 7);
        s += weighted(p[4][3] | p[5][2], 7);
        s += weighted(p[0][7] & p[1][6], 8);
        s += weighted(p[1][7], 8);
        s += weighted(p[2][5] & p[3][4], 8);
        s += weighted(p[2][6] | p[3][5], 8);
        s += weighted(p[4][4] & p[5][3], 8);
        s += weighted(p[4][4] ^ p[5][3], 8);
        s += weighted(p[2][7] | p[3][6], 9);
        s += weighted(p[4][5] ^ p[5][4], 9);
        s += weighted(p[3][7], 10);
        s += weighted(p[4][5] & p[5][4], 10);
        s += weighted(p[4][6] & p[5][5], 10);
        s += weighted(p[4][6] | p[5][5], 10);
        s += weighted(p[4][7] ^ p[5][6], 11);
        s += weighted(p[4][7] & p[5][6], 12);
        s += weighted(p[5][7], 12);
        return s[15:0];   // product wraps at 16 bits.
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // window sum is compared on every done cycle.
    always @(negedge clk) begin
        if (rst_n && done) begin
            check({test_name, " sum"}, exp_acc, acc_out);
        end
    end

    // one window of 25 taps; exact keeps pixel bits to 6 and 7.
    task automatic run_window(input string name, input bit exact, input bit strays);
        logic [15:0]     r;
        lenet_pkg::pix_t x;
        lenet_pkg::wgt_t y;
        int              gap;
        int              sent;
        int              cycles;
        test_name = name;
        exp_acc   = '0;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check({name, " cleared"}, 0, acc_out);
        check({name, " busy"}, 1, busy);
        sent = 0;
        while (sent < lenet_pkg::TAP_COUNT) begin
            rand_bits(2, r);
            gap = int'(r[1:0]);
            for (int g = 0; g < gap; g++) begin
                @(negedge clk);
            end
            if (strays && sent == 10) begin
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end
            rand_bits(8, r);
            x = exact ? {r[1:0], 6'b000000} : r[7:0];
            rand_bits(8, r);
            y = r[7:0];
            pix      = x;
            wgt      = y;
            in_valid = 1'b1;
            if (exact) begin
                exp_acc = exp_acc + lenet_pkg::acc_t'(x) * lenet_pkg::acc_t'(y);
            end else begin
                exp_acc = exp_acc + lenet_pkg::acc_t'(approx_ref(x, y));
            end
            sent++;
            @(negedge clk);
            in_valid = 1'b0;
        end
        // first cycle of flush.
        if (strays) begin
            rand_bits(16, r);
            pix      = r[7:0] | 8'h80;
            wgt      = r[15:8] | 8'h80;
            in_valid = 1'b1;
        end
        cycles = 1;
        while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            in_valid = 1'b0;
            cycles++;
        end
        in_valid = 1'b0;
        if (done !== 1'b1) begin
            errors++;
            $display("timeout: %s saw no done within %0d cycles", name, WAIT_LIMIT);
        end else begin
            check({name, " done delay"}, 2, cycles);
            check({name, " busy with done"}, 1, busy);
            @(negedge clk);
            check({name, " done width"}, 0, done);
            check({name, " busy after done"}, 0, busy);
            rand_bits(2, r);
            gap = int'(r[1:0]) + 2;
            if (strays) begin
                rand_bits(16, r);
                pix      = r[7:0] | 8'h80;
                wgt      = r[15:8] | 8'h80;
                in_valid = 1'b1;   // dropped while idle.
                @(negedge clk);
                in_valid = 1'b0;
            end
            repeat (gap) @(negedge clk);
            check({name, " hold"}, exp_acc, acc_out);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        in_valid  = 1'b0;
        pix       = '0;
        wgt       = '0;
        lfsr      = 16'd81;
        errors    = 0;
        checks    = 0;
        exp_acc   = '0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("reset busy", 0, busy);
        check("reset done", 0, done);
        check("reset acc_out", 0, acc_out);

        run_window("exact_rows", 1'b1, 1'b0);
        run_window("exact_rows", 1'b1, 1'b0);
        repeat (4) run_window("random", 1'b0, 1'b0);
        repeat (2) run_window("ignored_inputs", 1'b0, 1'b1);
        run_window("random_after_strays", 1'b0, 1'b0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
